// ==== common/aluPkg.sv ====
// Execute slice shared constants
package aluPkg;

    //////////////////////////////////////////////////////////////////////////
    // Data path and register file sizes
    //////////////////////////////////////////////////////////////////////////

    localparam int dataWidth    = 32;                 // Data path width
    localparam int regCount     = 32;                 // Architectural registers
    localparam int regAddrWidth = $clog2(regCount);   // 5 address bits
    localparam int aluOpWidth   = 4;                  // Bits 3:2 pick the group

    //////////////////////////////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////////////////////////////

    // Arithmetic group 00, bit 1 inverts B and carries in one
    localparam logic [aluOpWidth-1:0] aluAdd  = 4'b0000;
    localparam logic [aluOpWidth-1:0] aluSub  = 4'b0010;

    // Logic group 01, bits 1:0 select the function
    localparam logic [aluOpWidth-1:0] aluAnd  = 4'b0100;
    localparam logic [aluOpWidth-1:0] aluOr   = 4'b0101;
    localparam logic [aluOpWidth-1:0] aluXor  = 4'b0110;
    localparam logic [aluOpWidth-1:0] aluNor  = 4'b0111;

    // Set-less-than group 10, bit 0 set for unsigned compare
    localparam logic [aluOpWidth-1:0] aluSlt  = 4'b1010;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'b1011;

    //////////////////////////////////////////////////////////////////////////
    // MIPS opcode and funct fields
    //////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] opRType = 6'h00;   // Funct decides the op
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opSlti  = 6'h0A;
    localparam logic [5:0] opSltiu = 6'h0B;
    localparam logic [5:0] opAndi  = 6'h0C;   // Zero-extended immediates from here
    localparam logic [5:0] opOri   = 6'h0D;
    localparam logic [5:0] opXori  = 6'h0E;

    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnNor   = 6'h27;
    localparam logic [5:0] fnSlt   = 6'h2A;
    localparam logic [5:0] fnSltu  = 6'h2B;

endpackage

// ==== alu/rippleAdder.sv ====
// Ripple-carry adder
module rippleAdder import aluPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] sum,
    output logic                 carryOut
);

    logic [dataWidth:0] carry;   // carry[i] enters cell i

    assign carry[0] = carryIn;            // One for subtract and compare
    assign carryOut = carry[dataWidth];   // Inverted borrow when subtracting

    //////////////////////////////////////////////////////////////////////////
    // Full-adder chain, one cell per bit
    //////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < dataWidth; i++) begin : gCell
        logic halfSum;     // a ^ b
        logic genCarry;    // Generate term
        logic propCarry;   // Propagated carry in

        xor sumHalf (halfSum, a[i], b[i]);
        xor sumFull (sum[i], halfSum, carry[i]);

        and carryGen  (genCarry, a[i], b[i]);
        and carryProp (propCarry, halfSum, carry[i]);

        // Either term passes the carry on
        or  carryNext (carry[i+1], genCarry, propCarry);
    end

endmodule

// ==== alu/alu.sv ====
// Integer ALU
module alu import aluPkg::*; (
    input  logic [aluOpWidth-1:0] op,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    output logic [dataWidth-1:0]  y,
    output logic                  zero
);

    logic [dataWidth-1:0] bMaybeInv;   // B or ~B into the adder
    logic [dataWidth-1:0] arithY;      // Full sum or difference
    logic                 carryOut;
    logic                 overflow;    // Signed overflow of a + bMaybeInv
    logic                 lessSigned;
    logic                 lessUnsigned;
    logic [dataWidth-1:0] logicY;
    logic [dataWidth-1:0] sltY;

    //////////////////////////////////////////////////////////////////////////
    // Arithmetic unit
    //////////////////////////////////////////////////////////////////////////

    assign bMaybeInv = op[1] ? ~b : b;   // Two's complement with carry in below

    rippleAdder adder (
        .a        (a),
        .b        (bMaybeInv),
        .carryIn  (op[1]),           // Subtract adds the missing one
        .sum      (arithY),
        .carryOut (carryOut)
    );

    // Operands agree in sign but the result does not
    assign overflow = (a[dataWidth-1] == bMaybeInv[dataWidth-1]) &&
                      (arithY[dataWidth-1] != a[dataWidth-1]);

    //////////////////////////////////////////////////////////////////////////
    // Logic unit
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op[1:0])
            2'b00:   logicY = a & b;
            2'b01:   logicY = a | b;
            2'b10:   logicY = a ^ b;
            default: logicY = ~(a | b);   // Nor
        endcase
    end

    //////////////////////////////////////////////////////////////////////////
    // Set-less-than from the subtraction
    //////////////////////////////////////////////////////////////////////////

    assign lessSigned   = arithY[dataWidth-1] ^ overflow;   // Sign fixed by overflow
    assign lessUnsigned = ~carryOut;                        // Borrow out of a - b

    assign sltY = {{(dataWidth-1){1'b0}}, op[0] ? lessUnsigned : lessSigned};

    // Group select on the upper op bits
    always_comb begin
        case (op[3:2])
            2'b00:   y = arithY;
            2'b01:   y = logicY;
            2'b10:   y = sltY;
            default: y = '0;   // Unused group
        endcase
    end

    assign zero = ~|y;

endmodule

// ==== source/aluDecoder.sv ====
// Instruction to ALU operation decoder
module aluDecoder import aluPkg::*; (
    input  logic [dataWidth-1:0]  instr,
    output logic [aluOpWidth-1:0] aluOp,
    output logic                  useImm,
    output logic                  signExt,
    output logic                  writesRd,
    output logic                  legal
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];   // Only meaningful for R-type

    always_comb begin
        // Defaults describe an illegal word
        aluOp    = aluAdd;
        useImm   = 1'b0;
        signExt  = 1'b0;
        writesRd = 1'b0;
        legal    = 1'b0;

        case (opcode)
            opRType: begin
                writesRd = 1'b1;   // rd <= rs op rt
                legal    = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: legal = 1'b0;   // Unlisted funct
                endcase
            end
            opAddi, opSlti, opSltiu: begin
                useImm  = 1'b1;
                signExt = 1'b1;     // sltiu compares unsigned but still sign-extends
                legal   = 1'b1;
                case (opcode)
                    opSlti:  aluOp = aluSlt;
                    opSltiu: aluOp = aluSltu;
                    default: aluOp = aluAdd;
                endcase
            end
            opAndi, opOri, opXori: begin
                useImm = 1'b1;      // Zero-extended immediate
                legal  = 1'b1;
                case (opcode)
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    default: aluOp = aluXor;
                endcase
            end
            default: legal = 1'b0;  // Unlisted opcode
        endcase
    end

endmodule

// ==== source/registerFile.sv ====
// Two-read one-write register file
module registerFile import aluPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    writeEnable,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB
);

    logic [dataWidth-1:0] regs [regCount];   // Entry 0 never written

    //////////////////////////////////////////////////////////////////////////
    // Synchronous write port
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;   // All registers start cleared
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;   // Register 0 drops writes
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Combinational read ports
    //////////////////////////////////////////////////////////////////////////

    // Register 0 is forced to zero on both ports
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== source/executeTop.sv ====
// Integer execute slice
module executeTop import aluPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instrValid,
    input  logic [dataWidth-1:0]    instr,
    output logic                    resultValid,
    output logic                    zero,
    output logic                    illegal,
    output logic [dataWidth-1:0]    result,
    output logic [regAddrWidth-1:0] resultReg
);

    logic [aluOpWidth-1:0]   aluOp;
    logic                    useImm;
    logic                    signExt;
    logic                    writesRd;
    logic                    legal;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    immExt;       // Extended 16-bit immediate
    logic [dataWidth-1:0]    operandB;
    logic [dataWidth-1:0]    aluY;
    logic                    aluZero;
    logic [regAddrWidth-1:0] destReg;      // rd for R-type, rt otherwise
    logic                    writeEnable;

    aluDecoder decoder (
        .instr    (instr),
        .aluOp    (aluOp),
        .useImm   (useImm),
        .signExt  (signExt),
        .writesRd (writesRd),
        .legal    (legal)
    );

    registerFile regFile (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .readAddrA   (instr[25:21]),   // rs
        .readAddrB   (instr[20:16]),   // rt
        .writeAddr   (destReg),
        .writeData   (aluY),           // Written back at the edge that ends the cycle
        .readDataA   (rsData),
        .readDataB   (rtData)
    );

    //////////////////////////////////////////////////////////////////////////
    // Operand select and destination
    //////////////////////////////////////////////////////////////////////////

    assign immExt = signExt ? {{(dataWidth-16){instr[15]}}, instr[15:0]}
                            : {{(dataWidth-16){1'b0}}, instr[15:0]};

    assign operandB    = useImm ? immExt : rtData;
    assign destReg     = writesRd ? instr[15:11] : instr[20:16];
    assign writeEnable = instrValid && legal;   // Illegal words write nothing

    alu execAlu (
        .op   (aluOp),
        .a    (rsData),
        .b    (operandB),
        .y    (aluY),
        .zero (aluZero)
    );

    // Result stage, one cycle after the instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
            result      <= '0;
            zero        <= 1'b1;   // Matches the cleared result
            resultReg   <= '0;
        end else begin
            resultValid <= instrValid && legal;
            illegal     <= instrValid && !legal;   // One-cycle pulse
            if (instrValid) begin
                result    <= aluY;
                zero      <= aluZero;
                resultReg <= destReg;
            end
        end
    end

endmodule

// ==== tb/executeTop_properties.sv ====
// Execute slice assertions
module executeTop_properties import aluPkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 resultValid,
    input logic                 illegal,
    input logic                 zero,
    input logic [dataWidth-1:0] result
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////////
    // Output stage rules
    //////////////////////////////////////////////////////////////////////////

    // Both status outputs come out of reset low
    property quietAfterReset;
        @(posedge clk) reset |=> (!resultValid && !illegal);
    endproperty

    // One outcome per instruction
    property exclusiveStatus;
        @(posedge clk) disable iff (reset) !(resultValid && illegal);
    endproperty

    property zeroFlagMatches;
        @(posedge clk) disable iff (reset)
            resultValid |-> (zero == (result == '0));
    endproperty

    assert property (quietAfterReset)
        else $error("resultValid or illegal high after reset");
    assert property (exclusiveStatus)
        else $error("resultValid and illegal high together");
    assert property (zeroFlagMatches)
        else $error("zero flag disagrees with result");

endmodule

bind executeTop executeTop_properties props (
    .clk         (clk),
    .reset       (reset),
    .resultValid (resultValid),
    .illegal     (illegal),
    .zero        (zero),
    .result      (result)
);

// ==== tb/executeTb.sv ====
// Execute slice testbench
module executeTb import aluPkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycleLimit  = 400;   // About 300 stimulus cycles plus margin
    localparam int randomCount = 220;

    typedef struct packed {
        logic                    legal;
        logic [dataWidth-1:0]    value;
        logic [regAddrWidth-1:0] dest;
    } expectT;

    logic                    clk;
    logic                    reset;
    logic                    instrValid;
    logic [dataWidth-1:0]    instr;
    logic                    resultValid;
    logic                    zero;
    logic                    illegal;
    logic [dataWidth-1:0]    result;
    logic [regAddrWidth-1:0] resultReg;

    logic [dataWidth-1:0] shadow [regCount];   // Architectural state seen by the model
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    executeTop dut_i (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .zero        (zero),
        .illegal     (illegal),
        .result      (result),
        .resultReg   (resultReg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    //////////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////////

    function automatic expectT refModel(logic [dataWidth-1:0] w);
        logic [5:0]           opcode;
        logic [5:0]           funct;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] immS;
        logic [dataWidth-1:0] immZ;
        expectT               e;
        opcode  = w[31:26];
        funct   = w[5:0];
        a       = shadow[w[25:21]];
        b       = shadow[w[20:16]];
        immS    = {{16{w[15]}}, w[15:0]};   // addi, slti, sltiu
        immZ    = {16'h0000, w[15:0]};      // andi, ori, xori
        e.legal = 1'b1;
        e.dest  = w[20:16];                 // rt unless R-type
        e.value = '0;
        case (opcode)
            opRType: begin
                e.dest = w[15:11];
                case (funct)
                    fnAdd:   e.value = a + b;
                    fnSub:   e.value = a - b;
                    fnAnd:   e.value = a & b;
                    fnOr:    e.value = a | b;
                    fnXor:   e.value = a ^ b;
                    fnNor:   e.value = ~(a | b);
                    fnSlt:   e.value = ($signed(a) < $signed(b)) ? 1 : 0;
                    fnSltu:  e.value = (a < b) ? 1 : 0;
                    default: e.legal = 1'b0;
                endcase
            end
            opAddi:  e.value = a + immS;
            opSlti:  e.value = ($signed(a) < $signed(immS)) ? 1 : 0;
            opSltiu: e.value = (a < immS) ? 1 : 0;
            opAndi:  e.value = a & immZ;
            opOri:   e.value = a | immZ;
            opXori:  e.value = a ^ immZ;
            default: e.legal = 1'b0;
        endcase
        return e;
    endfunction

    task automatic compareValue(string sigName, logic [dataWidth-1:0] got,
                                logic [dataWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", sigName, got, exp);
        end
    endtask

    // Sample the instruction at the edge, check its result half a cycle later
    initial begin : compare
        logic                 sampledValid;
        logic [dataWidth-1:0] sampledInstr;
        expectT               exp;
        forever begin
            @(posedge clk);
            if (!reset) begin
                sampledValid = instrValid;
                sampledInstr = instr;
                exp          = refModel(sampledInstr);
                @(negedge clk);
                if (!sampledValid) begin
                    compareValue("resultValid", resultValid, 0);
                    compareValue("illegal", illegal, 0);
                end else if (exp.legal) begin
                    compareValue("resultValid", resultValid, 1);
                    compareValue("illegal", illegal, 0);
                    compareValue("result", result, exp.value);
                    compareValue("zero", zero, (exp.value == '0));
                    compareValue("resultReg", resultReg, exp.dest);
                    if (exp.dest != '0) begin
                        shadow[exp.dest] = exp.value;   // Register 0 stays zero
                    end
                end else begin
                    compareValue("resultValid", resultValid, 0);
                    compareValue("illegal", illegal, 1);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeR(logic [5:0] fn, logic [4:0] rd,
                                            logic [4:0] rs, logic [4:0] rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rt,
                                            logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic issue(logic [31:0] w);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= w;
    endtask

    // Mix of legal R-type, legal I-type and illegal words on registers 0 to 7
    function automatic logic [31:0] randomInstr();
        logic [5:0] functs [8];
        logic [5:0] iOps [6];
        int         kind;
        functs = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
        iOps   = '{opAddi, opSlti, opSltiu, opAndi, opOri, opXori};
        kind   = $urandom_range(0, 9);
        if (kind < 5) begin
            return encodeR(functs[$urandom_range(0, 7)], $urandom_range(0, 7),
                           $urandom_range(0, 7), $urandom_range(0, 7));
        end else if (kind < 8) begin
            return encodeI(iOps[$urandom_range(0, 5)], $urandom_range(0, 7),
                           $urandom_range(0, 7), $urandom_range(0, 16'hFFFF));
        end else if (kind == 8) begin
            return encodeR($urandom_range(0, 63), $urandom_range(0, 7),
                           $urandom_range(0, 7), $urandom_range(0, 7));
        end
        return {6'($urandom_range(0, 63)), 26'($urandom)};   // Mostly illegal opcodes
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Directed and random sequence
    //////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(52));
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < regCount; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        issue(encodeR(fnAdd, 3, 1, 2));               // Unwritten registers give zero

        issue(encodeI(opAddi, 1, 0, 16'h1234));
        issue(encodeI(opAddi, 2, 0, 16'hFFFB));       // -5
        issue(encodeR(fnAdd, 3, 1, 2));
        issue(encodeR(fnSub, 4, 1, 2));
        issue(encodeR(fnSub, 5, 1, 1));               // Equal operands set zero
        issue(encodeI(opAddi, 6, 2, 16'h8000));

        issue(encodeI(opAddi, 7, 0, 16'h5A5A));
        issue(encodeI(opAddi, 8, 0, 16'hF0F0));       // 0xFFFFF0F0
        issue(encodeR(fnAnd, 9, 7, 8));
        issue(encodeR(fnOr, 10, 7, 8));
        issue(encodeR(fnXor, 11, 7, 8));
        issue(encodeR(fnNor, 12, 7, 8));
        issue(encodeI(opAndi, 13, 8, 16'h8FFF));      // Upper bits must clear
        issue(encodeI(opOri, 14, 0, 16'h8000));
        issue(encodeI(opXori, 15, 8, 16'hFFFF));

        issue(encodeI(opAddi, 21, 0, 16'h8000));      // Doubled up to 0x80000000
        repeat (16) issue(encodeR(fnAdd, 21, 21, 21));
        issue(encodeI(opAddi, 22, 0, 16'h0001));
        issue(encodeR(fnSlt, 23, 21, 22));
        issue(encodeR(fnSltu, 24, 21, 22));
        issue(encodeR(fnSlt, 23, 22, 21));
        issue(encodeR(fnSltu, 24, 22, 21));
        issue(encodeI(opAddi, 25, 0, 16'hFFFF));      // -1
        issue(encodeR(fnSlt, 26, 25, 0));
        issue(encodeR(fnSltu, 27, 25, 0));
        issue(encodeI(opSltiu, 28, 0, 16'hFFFF));
        issue(encodeI(opSlti, 29, 0, 16'hFFFF));
        issue(encodeR(fnAdd, 30, 21, 21));            // Wraps to zero

        issue(encodeI(opAddi, 0, 0, 16'd55));         // Reported but not kept
        issue(encodeR(fnAdd, 16, 0, 0));
        issue(encodeI(opAddi, 17, 0, 16'd7));
        issue(encodeR(fnAdd, 18, 17, 17));            // Reads r17 the next cycle

        issue(encodeI(opAddi, 19, 0, 16'd99));
        issue(encodeI(6'h3F, 19, 0, 16'h1111));       // Unlisted opcode
        issue(encodeR(6'h00, 19, 0, 0));              // Unlisted funct
        issue(encodeI(6'h09, 19, 0, 16'h2222));
        issue(encodeR(fnAdd, 20, 19, 0));             // r19 still 99

        repeat (randomCount) issue(randomInstr());

        @(posedge clk);
        instrValid <= 1'b0;
        repeat (3) @(posedge clk);   // Last idle check done at the negedge before
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
common/aluPkg.sv
alu/rippleAdder.sv
alu/alu.sv
source/aluDecoder.sv
source/registerFile.sv
source/executeTop.sv
tb/executeTop_properties.sv
tb/executeTb.sv

// ==== Bender.yml ====
package:
  name: execute_slice

sources:
  - common/aluPkg.sv
  - alu/rippleAdder.sv
  - alu/alu.sv
  - source/aluDecoder.sv
  - source/registerFile.sv
  - source/executeTop.sv
  - target: test
    files:
      - tb/executeTop_properties.sv
      - tb/executeTb.sv
